// File: verilog/cv_ctrl_defs.svh
`ifndef CV_CTRL_DEFS_SVH
`define CV_CTRL_DEFS_SVH

// ========================================
// Word widths
// ========================================
`define CV_JOY_W       20
`define CV_NUM_KEYS    14
`define CV_NUM_DIGITS  10
`define CV_QUAD_W      4

// Host joystick word bit positions
`define CV_JOY_RIGHT   0
`define CV_JOY_LEFT    1
`define CV_JOY_DOWN    2
`define CV_JOY_UP      3
`define CV_JOY_FIRE1   4
`define CV_JOY_FIRE2   5
`define CV_JOY_STAR    6
`define CV_JOY_NUMBER  7
`define CV_JOY_DIGIT0  8
`define CV_JOY_PT      18
`define CV_JOY_BT      19

// Positions in the keypad key field
`define CV_KPOS_STAR   10
`define CV_KPOS_NUMBER 11
`define CV_KPOS_PT     12
`define CV_KPOS_BT     13

// ========================================
// Keypad quad codes, active low
// ========================================
`define CV_KEY_0       4'b0011
`define CV_KEY_1       4'b1110
`define CV_KEY_2       4'b1101
`define CV_KEY_3       4'b0110
`define CV_KEY_4       4'b0001
`define CV_KEY_5       4'b1001
`define CV_KEY_6       4'b0111
`define CV_KEY_7       4'b1100
`define CV_KEY_8       4'b1000
`define CV_KEY_9       4'b1011
`define CV_KEY_STAR    4'b1010
`define CV_KEY_NUMBER  4'b0101
`define CV_KEY_PT      4'b0100
`define CV_KEY_BT      4'b0010
`define CV_KEY_NONE    4'b1111

`endif

// File: verilog/cv_ctrl_pkg.sv
`default_nettype none

`include "cv_ctrl_defs.svh"

package cv_ctrl_pkg;

	// ========================================
	// Keypad word layout
	// ========================================

	// Named view of one keypad word
	// All bits active high
	typedef struct packed {
		// Bit 0 is key 0 up to bit 9 for key 9
		// then star, number, purple and blue
		logic [`CV_NUM_KEYS-1:0] keys;
		logic                    up;
		logic                    down;
		logic                    left;
		logic                    right;
		// Joystick select fire
		logic                    fire1;
		// Keypad select fire
		logic                    fire2;
	} keypad_fields_t;

	// Same word read either flat or by field
	typedef union packed {
		logic [`CV_JOY_W-1:0] flat;
		keypad_fields_t       fields;
	} keypad_word_t;

endpackage

`default_nettype wire

// File: verilog/ps2_keypad_emu.sv
`timescale 1ns/100ps
`default_nettype none

`include "cv_ctrl_defs.svh"

module ps2_keypad_emu
	import cv_ctrl_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst_n_i,
	input  logic         key_strobe_i,
	input  logic         key_pressed_i,
	input  logic [7:0]   key_code_i,
	output keypad_word_t kbd_word_o
);

	// ========================================
	// Scancodes
	// ========================================

	// Main row digits
	localparam logic [7:0] SC_MAIN_0 = 8'h45;
	localparam logic [7:0] SC_MAIN_1 = 8'h16;
	localparam logic [7:0] SC_MAIN_2 = 8'h1E;
	localparam logic [7:0] SC_MAIN_3 = 8'h26;
	localparam logic [7:0] SC_MAIN_4 = 8'h25;
	localparam logic [7:0] SC_MAIN_5 = 8'h2E;
	localparam logic [7:0] SC_MAIN_6 = 8'h36;
	localparam logic [7:0] SC_MAIN_7 = 8'h3D;
	localparam logic [7:0] SC_MAIN_8 = 8'h3E;
	localparam logic [7:0] SC_MAIN_9 = 8'h46;

	// Numeric pad digits
	localparam logic [7:0] SC_PAD_0 = 8'h70;
	localparam logic [7:0] SC_PAD_1 = 8'h69;
	localparam logic [7:0] SC_PAD_2 = 8'h72;
	localparam logic [7:0] SC_PAD_3 = 8'h7A;
	localparam logic [7:0] SC_PAD_4 = 8'h6B;
	localparam logic [7:0] SC_PAD_5 = 8'h73;
	localparam logic [7:0] SC_PAD_6 = 8'h74;
	localparam logic [7:0] SC_PAD_7 = 8'h6C;
	localparam logic [7:0] SC_PAD_8 = 8'h75;
	localparam logic [7:0] SC_PAD_9 = 8'h7D;

	localparam logic [7:0] SC_STAR    = 8'h7C;
	localparam logic [7:0] SC_LSHIFT  = 8'h12;
	localparam logic [7:0] SC_RSHIFT  = 8'h59;
	localparam logic [7:0] SC_MINUS   = 8'h7B;

	// Held button state
	logic [`CV_NUM_DIGITS-1:0] btn_digit;
	logic                      btn_star;
	logic                      btn_shift;
	logic                      btn_minus;

	// ========================================
	// Button state update
	// ========================================

	// Every strobe is taken
	// Extended prefix and unknown codes fall through unchanged
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			btn_digit <= '0;
			btn_star  <= 1'b0;
			btn_shift <= 1'b0;
			btn_minus <= 1'b0;
		end else if (key_strobe_i) begin
			case (key_code_i)
				SC_MAIN_0, SC_PAD_0: btn_digit[0] <= key_pressed_i;
				SC_MAIN_1, SC_PAD_1: btn_digit[1] <= key_pressed_i;
				SC_MAIN_2, SC_PAD_2: btn_digit[2] <= key_pressed_i;
				SC_MAIN_3, SC_PAD_3: btn_digit[3] <= key_pressed_i;
				SC_MAIN_4, SC_PAD_4: btn_digit[4] <= key_pressed_i;
				SC_MAIN_5, SC_PAD_5: btn_digit[5] <= key_pressed_i;
				SC_MAIN_6, SC_PAD_6: btn_digit[6] <= key_pressed_i;
				SC_MAIN_7, SC_PAD_7: btn_digit[7] <= key_pressed_i;
				SC_MAIN_8, SC_PAD_8: btn_digit[8] <= key_pressed_i;
				SC_MAIN_9, SC_PAD_9: btn_digit[9] <= key_pressed_i;
				SC_STAR:               btn_star  <= key_pressed_i;
				SC_LSHIFT, SC_RSHIFT:  btn_shift <= key_pressed_i;
				SC_MINUS:              btn_minus <= key_pressed_i;
				default: ;
			endcase
		end
	end

	// ========================================
	// Keyboard keypad word
	// ========================================

	// Only the key field is driven
	// Directions and fires stay clear
	always_comb begin
		kbd_word_o = '0;
		kbd_word_o.fields.keys[`CV_NUM_DIGITS-1:0] = btn_digit;
		// Shift+8 gives star, shift+3 gives number
		kbd_word_o.fields.keys[`CV_KPOS_STAR]   = btn_star | (btn_shift & btn_digit[8]);
		kbd_word_o.fields.keys[`CV_KPOS_NUMBER] = btn_minus | (btn_shift & btn_digit[3]);
	end

endmodule

`default_nettype wire

// File: verilog/cv_ctrl_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "cv_ctrl_defs.svh"

module cv_ctrl_port
	import cv_ctrl_pkg::*;
(
	input  logic [`CV_JOY_W-1:0]  joy_i,
	input  keypad_word_t          kbd_word_i,
	input  logic                  key_sel_n_i,
	input  logic                  joy_sel_n_i,
	output logic [`CV_QUAD_W-1:0] quad_n_o,
	output logic                  fire_n_o
);

	keypad_word_t             joy_word;
	keypad_word_t             merged;
	logic [`CV_NUM_KEYS-1:0]  key_vec;
	logic [`CV_QUAD_W-1:0]    enc_code;
	logic [`CV_QUAD_W-1:0]    key_quad;
	logic [`CV_QUAD_W-1:0]    joy_quad;
	logic                     key_fire_n;
	logic                     joy_fire_n;

	// Quad code of one key position
	function automatic logic [`CV_QUAD_W-1:0] key_code(input int idx);
		case (idx)
			0:       key_code = `CV_KEY_0;
			1:       key_code = `CV_KEY_1;
			2:       key_code = `CV_KEY_2;
			3:       key_code = `CV_KEY_3;
			4:       key_code = `CV_KEY_4;
			5:       key_code = `CV_KEY_5;
			6:       key_code = `CV_KEY_6;
			7:       key_code = `CV_KEY_7;
			8:       key_code = `CV_KEY_8;
			9:       key_code = `CV_KEY_9;
			10:      key_code = `CV_KEY_STAR;
			11:      key_code = `CV_KEY_NUMBER;
			12:      key_code = `CV_KEY_PT;
			13:      key_code = `CV_KEY_BT;
			default: key_code = `CV_KEY_NONE;
		endcase
	endfunction

	// ========================================
	// Joystick remap and merge
	// ========================================

	always_comb begin
		joy_word.fields.keys[`CV_NUM_DIGITS-1:0] = joy_i[`CV_JOY_DIGIT0 +: `CV_NUM_DIGITS];
		joy_word.fields.keys[`CV_KPOS_STAR]      = joy_i[`CV_JOY_STAR];
		joy_word.fields.keys[`CV_KPOS_NUMBER]    = joy_i[`CV_JOY_NUMBER];
		joy_word.fields.keys[`CV_KPOS_PT]        = joy_i[`CV_JOY_PT];
		joy_word.fields.keys[`CV_KPOS_BT]        = joy_i[`CV_JOY_BT];
		joy_word.fields.up    = joy_i[`CV_JOY_UP];
		joy_word.fields.down  = joy_i[`CV_JOY_DOWN];
		joy_word.fields.left  = joy_i[`CV_JOY_LEFT];
		joy_word.fields.right = joy_i[`CV_JOY_RIGHT];
		joy_word.fields.fire1 = joy_i[`CV_JOY_FIRE1];
		joy_word.fields.fire2 = joy_i[`CV_JOY_FIRE2];
	end

	always_comb begin
		merged.flat = joy_word.flat | kbd_word_i.flat;
	end

	// Key field sits at the top of the flat word
	assign key_vec = merged.flat[`CV_JOY_W-1 -: `CV_NUM_KEYS];

	// ========================================
	// Priority encoder
	// ========================================

	// Scan from the top so the lowest key set wins
	always_comb begin
		enc_code = `CV_KEY_NONE;
		for (int k = `CV_NUM_KEYS - 1; k >= 0; k--) begin
			if (key_vec[k]) begin
				enc_code = key_code(k);
			end
		end
	end

	// Deselected components read all ones
	assign key_quad   = key_sel_n_i ? '1 : enc_code;
	assign key_fire_n = key_sel_n_i | ~merged.fields.fire2;

	assign joy_quad   = joy_sel_n_i ? '1 :
		~{merged.fields.up, merged.fields.down, merged.fields.left, merged.fields.right};
	assign joy_fire_n = joy_sel_n_i | ~merged.fields.fire1;

	// Both selects low overlap on the shared lines
	assign quad_n_o = key_quad & joy_quad;
	assign fire_n_o = key_fire_n & joy_fire_n;

endmodule

`default_nettype wire

// File: verilog/cv_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "cv_ctrl_defs.svh"

module cv_ctrl_top
	import cv_ctrl_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  rst_n_i,
	input  logic                  swap_i,
	input  logic                  key_strobe_i,
	input  logic                  key_pressed_i,
	input  logic [7:0]            key_code_i,
	input  logic [`CV_JOY_W-1:0]  joy0_i,
	input  logic [`CV_JOY_W-1:0]  joy1_i,
	input  logic [1:0]            key_sel_n_i,
	input  logic [1:0]            joy_sel_n_i,
	output logic [`CV_QUAD_W-1:0] quad0_n_o,
	output logic [`CV_QUAD_W-1:0] quad1_n_o,
	output logic                  fire0_n_o,
	output logic                  fire1_n_o
);

	keypad_word_t            kbd_word;
	logic [`CV_JOY_W-1:0]    joy_p0;
	logic [`CV_JOY_W-1:0]    joy_p1;

	// Joystick swap with no register in the path
	assign joy_p0 = swap_i ? joy1_i : joy0_i;
	assign joy_p1 = swap_i ? joy0_i : joy1_i;

	// ========================================
	// Keyboard and ports
	// ========================================

	ps2_keypad_emu u_kbd (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.key_strobe_i  (key_strobe_i),
		.key_pressed_i (key_pressed_i),
		.key_code_i    (key_code_i),
		.kbd_word_o    (kbd_word)
	);

	// Keyboard feeds both ports
	cv_ctrl_port u_port0 (
		.joy_i       (joy_p0),
		.kbd_word_i  (kbd_word),
		.key_sel_n_i (key_sel_n_i[0]),
		.joy_sel_n_i (joy_sel_n_i[0]),
		.quad_n_o    (quad0_n_o),
		.fire_n_o    (fire0_n_o)
	);

	cv_ctrl_port u_port1 (
		.joy_i       (joy_p1),
		.kbd_word_i  (kbd_word),
		.key_sel_n_i (key_sel_n_i[1]),
		.joy_sel_n_i (joy_sel_n_i[1]),
		.quad_n_o    (quad1_n_o),
		.fire_n_o    (fire1_n_o)
	);

endmodule

`default_nettype wire

// File: dv/tb_cv_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "cv_ctrl_defs.svh"

module tb_cv_ctrl;

	localparam int RESET_CYCLES = 16;
	localparam int N_SEL_VECS   = 16;
	localparam int N_KEY_VECS   = 600;
	localparam int N_JOY_VECS   = 600;
	localparam int KBD_CYCLES   = 200;
	localparam int N_SWAP_VECS  = 500;
	// Stimulus length in cycles
	localparam int STIM_CYCLES  = RESET_CYCLES + N_SEL_VECS + N_KEY_VECS + N_JOY_VECS
		+ KBD_CYCLES + N_SWAP_VECS;
	localparam int MAX_CYCLES   = 2 * STIM_CYCLES;

	// Host word bit for each keypad key position
	localparam int HOST_POS [0:13] = '{8, 9, 10, 11, 12, 13, 14, 15, 16, 17, 6, 7, 18, 19};

	localparam logic [3:0] CODE_TAB [0:13] = '{
		`CV_KEY_0, `CV_KEY_1, `CV_KEY_2, `CV_KEY_3, `CV_KEY_4,
		`CV_KEY_5, `CV_KEY_6, `CV_KEY_7, `CV_KEY_8, `CV_KEY_9,
		`CV_KEY_STAR, `CV_KEY_NUMBER, `CV_KEY_PT, `CV_KEY_BT
	};

	// Scancodes indexed by digit
	localparam logic [7:0] MAIN_SC [0:9] = '{
		8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
	};
	localparam logic [7:0] PAD_SC [0:9] = '{
		8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B, 8'h73, 8'h74, 8'h6C, 8'h75, 8'h7D
	};
	localparam logic [7:0] SC_STAR   = 8'h7C;
	localparam logic [7:0] SC_LSHIFT = 8'h12;
	localparam logic [7:0] SC_RSHIFT = 8'h59;
	localparam logic [7:0] SC_MINUS  = 8'h7B;

	logic        clk_sys;
	logic        rst_n_i;
	logic        swap_i;
	logic        key_strobe_i;
	logic        key_pressed_i;
	logic [7:0]  key_code_i;
	logic [19:0] joy0_i;
	logic [19:0] joy1_i;
	logic [1:0]  key_sel_n_i;
	logic [1:0]  joy_sel_n_i;
	logic [3:0]  quad0_n_o;
	logic [3:0]  quad1_n_o;
	logic        fire0_n_o;
	logic        fire1_n_o;

	int          seed;
	int          errors = 0;
	int          checks = 0;
	int          cycle_cnt = 0;

	// Mirrored buttons by index
	// Digits at 0 to 9, then star, shift and minus
	logic [12:0] held;
	logic [13:0] kbd_keys;
	logic [4:0]  exp0;
	logic [4:0]  exp1;

	cv_ctrl_top uut (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.swap_i        (swap_i),
		.key_strobe_i  (key_strobe_i),
		.key_pressed_i (key_pressed_i),
		.key_code_i    (key_code_i),
		.joy0_i        (joy0_i),
		.joy1_i        (joy1_i),
		.key_sel_n_i   (key_sel_n_i),
		.joy_sel_n_i   (joy_sel_n_i),
		.quad0_n_o     (quad0_n_o),
		.quad1_n_o     (quad1_n_o),
		.fire0_n_o     (fire0_n_o),
		.fire1_n_o     (fire1_n_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#20 clk_sys = ~clk_sys;
		end
	end

	// ========================================
	// Reference model
	// ========================================

	function automatic int button_of(input logic [7:0] code);
		int idx;
		idx = -1;
		for (int d = 0; d < 10; d++) begin
			if (code == MAIN_SC[d] || code == PAD_SC[d]) begin
				idx = d;
			end
		end
		if (code == SC_STAR) idx = 10;
		if (code == SC_LSHIFT || code == SC_RSHIFT) idx = 11;
		if (code == SC_MINUS) idx = 12;
		return idx;
	endfunction

	// Button state follows the strobe on the same edge as the DUT
	always @(posedge clk_sys) begin
		if (!rst_n_i) begin
			held <= '0;
		end else if (key_strobe_i && button_of(key_code_i) >= 0) begin
			held[button_of(key_code_i)] <= key_pressed_i;
		end
	end

	always_comb begin
		kbd_keys        = '0;
		kbd_keys[9:0]   = held[9:0];
		kbd_keys[10]    = held[10] | (held[11] & held[8]);
		kbd_keys[11]    = held[12] | (held[11] & held[3]);
	end

	// Returns quad in the top four bits and fire in bit 0
	function automatic logic [4:0] expected_port(input logic [19:0] joy,
		input logic [13:0] kb, input logic ksel_n, input logic jsel_n);
		logic [3:0] kq;
		logic [3:0] jq;
		logic       kf;
		logic       jf;
		logic       found;
		kq = `CV_KEY_NONE;
		found = 1'b0;
		for (int k = 0; k < 14; k++) begin
			if (!found && (joy[HOST_POS[k]] || kb[k])) begin
				kq = CODE_TAB[k];
				found = 1'b1;
			end
		end
		kf = ~joy[5];
		// Up, down, left, right sit at host bits 3 to 0
		jq = ~joy[3:0];
		jf = ~joy[4];
		if (ksel_n) begin
			kq = 4'b1111;
			kf = 1'b1;
		end
		if (jsel_n) begin
			jq = 4'b1111;
			jf = 1'b1;
		end
		return {kq & jq, kf & jf};
	endfunction

	always_comb begin
		exp0 = expected_port(swap_i ? joy1_i : joy0_i, kbd_keys, key_sel_n_i[0],
			joy_sel_n_i[0]);
		exp1 = expected_port(swap_i ? joy0_i : joy1_i, kbd_keys, key_sel_n_i[1],
			joy_sel_n_i[1]);
	end

	// ========================================
	// Checks
	// ========================================

	task automatic report_mismatch(input string what, input logic [3:0] got,
		input logic [3:0] want);
		errors++;
		$display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, want);
	endtask

	quad0_matches: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		quad0_n_o == exp0[4:1])
		else report_mismatch("port 0 quad", $sampled(quad0_n_o), $sampled(exp0[4:1]));

	quad1_matches: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		quad1_n_o == exp1[4:1])
		else report_mismatch("port 1 quad", $sampled(quad1_n_o), $sampled(exp1[4:1]));

	fire0_matches: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		fire0_n_o == exp0[0])
		else report_mismatch("port 0 fire", {3'b000, $sampled(fire0_n_o)},
			{3'b000, $sampled(exp0[0])});

	fire1_matches: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		fire1_n_o == exp1[0])
		else report_mismatch("port 1 fire", {3'b000, $sampled(fire1_n_o)},
			{3'b000, $sampled(exp1[0])});

	// Shift combinations sit above the held digit, so the ports never show them
	kbd_word_matches: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		uut.kbd_word == {kbd_keys, 6'b000000})
		else begin
			errors++;
			$display("[FAIL] %0t: keyboard word is %h, expected %h", $time,
				$sampled(uut.kbd_word), $sampled({kbd_keys, 6'b000000}));
		end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (rst_n_i) begin
			checks <= checks + 5;
		end
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout: stimulus did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	// ========================================
	// Stimulus
	// ========================================

	// Clears keys below p, sets key p, leaves higher keys as given
	function automatic logic [19:0] shape_keys(input logic [19:0] word, input int p);
		logic [19:0] w;
		w = word;
		for (int k = 0; k < 14; k++) begin
			if (k < p) begin
				w[HOST_POS[k]] = 1'b0;
			end else if (k == p) begin
				w[HOST_POS[k]] = 1'b1;
			end
		end
		return w;
	endfunction

	task automatic send_key(input logic [7:0] code, input logic pressed);
		@(negedge clk_sys);
		key_strobe_i  = 1'b1;
		key_code_i    = code;
		key_pressed_i = pressed;
		@(negedge clk_sys);
		key_strobe_i  = 1'b0;
		key_pressed_i = 1'b0;
	endtask

	task automatic idle_select_sweep();
		for (int i = 0; i < N_SEL_VECS; i++) begin
			@(negedge clk_sys);
			key_sel_n_i = i[1:0];
			joy_sel_n_i = i[3:2];
		end
	endtask

	task automatic keypad_priority_vectors();
		logic [31:0] r;
		for (int i = 0; i < N_KEY_VECS; i++) begin
			@(negedge clk_sys);
			key_sel_n_i = 2'b00;
			joy_sel_n_i = 2'b11;
			// Position 14 means no key at all
			r = $random(seed);
			joy0_i = shape_keys(r[19:0], i % 15);
			r = $random(seed);
			joy1_i = shape_keys(r[19:0], (i + 7) % 15);
		end
	endtask

	task automatic joystick_mux_vectors();
		logic [31:0] r;
		for (int i = 0; i < N_JOY_VECS; i++) begin
			@(negedge clk_sys);
			joy_sel_n_i = 2'b00;
			key_sel_n_i = i[1:0];
			r = $random(seed);
			joy0_i = shape_keys(r[19:0], int'(r[27:24]) % 15);
			r = $random(seed);
			joy1_i = shape_keys(r[19:0], int'(r[27:24]) % 15);
		end
	endtask

	task automatic keyboard_sequence();
		@(negedge clk_sys);
		joy0_i      = '0;
		joy1_i      = '0;
		swap_i      = 1'b0;
		key_sel_n_i = 2'b00;
		joy_sel_n_i = 2'b10;
		for (int d = 0; d < 10; d++) begin
			send_key(MAIN_SC[d], 1'b1);
			send_key(MAIN_SC[d], 1'b0);
		end
		for (int d = 0; d < 10; d++) begin
			send_key(PAD_SC[d], 1'b1);
			send_key(PAD_SC[d], 1'b0);
		end
		// Lowest held digit wins as keys pile up and drop away
		for (int d = 9; d >= 0; d--) begin
			send_key(MAIN_SC[d], 1'b1);
		end
		for (int d = 0; d < 10; d++) begin
			send_key(MAIN_SC[d], 1'b0);
		end
		send_key(SC_STAR, 1'b1);
		send_key(SC_STAR, 1'b0);
		send_key(SC_MINUS, 1'b1);
		send_key(SC_MINUS, 1'b0);
		send_key(SC_LSHIFT, 1'b1);
		send_key(MAIN_SC[8], 1'b1);
		send_key(MAIN_SC[8], 1'b0);
		send_key(SC_LSHIFT, 1'b0);
		send_key(SC_RSHIFT, 1'b1);
		send_key(PAD_SC[3], 1'b1);
		send_key(SC_RSHIFT, 1'b0);
		send_key(PAD_SC[3], 1'b0);
		// Unknown codes while digit 5 is held
		send_key(MAIN_SC[5], 1'b1);
		send_key(8'h1C, 1'b1);
		send_key(8'hE0, 1'b1);
		send_key(8'hF0, 1'b0);
		send_key(8'h1C, 1'b0);
		send_key(MAIN_SC[5], 1'b0);
	endtask

	task automatic swap_vectors();
		logic [31:0] r;
		// Keyboard digit stays held under the swap traffic
		send_key(MAIN_SC[7], 1'b1);
		for (int i = 0; i < N_SWAP_VECS; i++) begin
			@(negedge clk_sys);
			r = $random(seed);
			swap_i      = r[31];
			key_sel_n_i = r[29:28];
			joy_sel_n_i = r[27:26];
			joy0_i      = shape_keys(r[19:0], int'(r[25:22]) % 15);
			r = $random(seed);
			joy1_i      = r[19:0];
		end
		send_key(MAIN_SC[7], 1'b0);
	endtask

	initial begin
		seed          = 32'h7671;
		rst_n_i       = 1'b0;
		swap_i        = 1'b0;
		key_strobe_i  = 1'b0;
		key_pressed_i = 1'b0;
		key_code_i    = '0;
		joy0_i        = '0;
		joy1_i        = '0;
		key_sel_n_i   = 2'b11;
		joy_sel_n_i   = 2'b11;

		// A press during reset has to be dropped
		repeat (8) @(negedge clk_sys);
		key_strobe_i  = 1'b1;
		key_code_i    = MAIN_SC[1];
		key_pressed_i = 1'b1;
		@(negedge clk_sys);
		key_strobe_i  = 1'b0;
		key_pressed_i = 1'b0;
		repeat (RESET_CYCLES - 9) @(negedge clk_sys);
		rst_n_i = 1'b1;

		idle_select_sweep();
		keypad_priority_vectors();
		joystick_mux_vectors();
		keyboard_sequence();
		swap_vectors();
		repeat (2) @(negedge clk_sys);

		$display("Done after %0d cycles: %0d checks, %0d errors", cycle_cnt, checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+verilog
verilog/cv_ctrl_pkg.sv
verilog/ps2_keypad_emu.sv
verilog/cv_ctrl_port.sv
verilog/cv_ctrl_top.sv
dv/tb_cv_ctrl.sv

// File: Makefile
# Verilator build and run for the controller front end

VERILATOR ?= verilator
TOP       := tb_cv_ctrl
FILELIST  := files.f
VFLAGS    := --binary --assert --timing --timescale 1ns/100ps -j 0 --top-module $(TOP)

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
HEADERS   := verilog/cv_ctrl_defs.svh
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(HEADERS)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@grep -q "Test passed" $(SIM_LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
